// File: common/board_pkg.sv
// Shared timing constants, pipeline structs and TM1638 FSM states; imported by every RTL block
package board_pkg;

    //----------------------------------------
    // Timing

    localparam int clk_mhz          = 100;  // System clock, sets the divider ratios below
    localparam int mic_sck_half     = 4;    // 12.5 MHz mic serial clock
    localparam int mic_frame_cycles = 4096; // About 24.4 kHz sample rate
    localparam int tm_clk_half      = 4;    // 12.5 MHz TM1638 serial clock

    //----------------------------------------
    // Board and LED-and-key widths

    localparam int w_key      = 4;
    localparam int w_tm_key   = 8;
    localparam int w_led      = 4;
    localparam int w_tm_led   = 8;
    localparam int w_tm_digit = 8;

    //----------------------------------------
    // Pipeline payloads

    typedef struct packed {
        logic        valid; // One-cycle strobe
        logic [11:0] value; // ADC result without leading zeros
    } mic_sample_t;

    typedef struct packed {
        logic        valid; // Pulses when the fields below change
        logic [10:0] mag;   // Gained magnitude around mid-scale
        logic [10:0] peak;  // Held maximum
        logic [7:0]  bar;   // Thermometer code
    } level_t;

    typedef struct packed {
        logic [w_tm_digit-1:0][7:0] segs; // hgfedcba, digit 0 leftmost
        logic [w_tm_led-1:0]        leds;
    } seg_frame_t;

    typedef enum logic [2:0] {
        idle,
        write_mode,
        write_addr,
        write_data,
        read_mode,
        read_keys,
        strobe_gap
    } tm_state_e;

endpackage

// File: mic_spi/mic_spi_receiver.sv
// PMOD MIC3 SPI master; frames one 16-bit ADC read per sample period and emits a sample strobe
`timescale 1ns/1ps

module mic_spi_receiver
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   sdo,
    output logic                   cs,
    output logic                   sck,
    output board_pkg::mic_sample_t sample
);

    import board_pkg::*;

    typedef logic [$clog2(mic_frame_cycles)-1:0] frame_cnt_t;

    frame_cnt_t  cnt;
    logic        in_frame;
    logic        sck_next;
    logic        cs_d;
    logic [15:0] shift;

    //----------------------------------------
    // Frame timing

    // 16 serial clock periods at the start of each sample period
    assign in_frame = cnt < frame_cnt_t'(16 * 2 * mic_sck_half);
    assign sck_next = in_frame && cnt[$clog2(mic_sck_half)];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cnt          <= '0;
            cs           <= 1'b1;
            cs_d         <= 1'b1; // No strobe out of reset
            sck          <= 1'b0;
            shift        <= '0;
            sample.valid <= 1'b0;
            sample.value <= '0;
        end
        else
        begin
            if (cnt == frame_cnt_t'(mic_frame_cycles - 1))
                cnt <= '0;
            else
                cnt <= cnt + 1'b1;

            cs   <= !in_frame;
            sck  <= sck_next;
            cs_d <= cs;

            if (sck_next && !sck) // Rising serial clock, MSB first
                shift <= {shift[14:0], sdo};

            // Strobe one cycle after chip select rises
            sample.valid <= cs && !cs_d;
            if (cs && !cs_d)
                sample.value <= shift[11:0];
        end
    end

endmodule

// File: logic/level_meter.sv
// Turns mic samples into a gained magnitude, a clearable peak hold and an 8-step LED bar
`timescale 1ns/1ps

module level_meter
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  board_pkg::mic_sample_t sample,
    input  logic [1:0]             gain,
    input  logic                   clear_peak,
    output board_pkg::level_t      level
);

    import board_pkg::*;

    logic [11:0] diff;
    logic [14:0] gained;
    logic [10:0] mag;
    logic [10:0] peak_next;
    logic [7:0]  bar_next;

    //----------------------------------------
    // Magnitude, peak and bar

    always_comb
    begin
        // Distance from mid-scale, 0 to 2048
        if (sample.value[11])
            diff = sample.value - 12'h800;
        else
            diff = 12'h800 - sample.value;

        gained = 15'(diff) << gain;
        mag    = (gained > 15'd2047) ? 11'h7ff : gained[10:0]; // Saturate

        if (clear_peak || (mag > level.peak))
            peak_next = mag;
        else
            peak_next = level.peak;

        for (int i = 0; i < 8; i++)
            bar_next[i] = mag > 11'(i * 256);
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            level <= '0;
        else
        begin
            level.valid <= sample.valid;
            if (sample.valid)
            begin
                level.mag  <= mag;
                level.peak <= peak_next;
                level.bar  <= bar_next;
            end
        end
    end

endmodule

// File: logic/seg_display_encoder.sv
// Builds the TM1638 display frame: peak and magnitude as hex digits, bar on the LEDs
`timescale 1ns/1ps

module seg_display_encoder
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  board_pkg::level_t     level,
    output board_pkg::seg_frame_t frame
);

    import board_pkg::*;

    seg_frame_t  frame_next;
    logic [11:0] peak_x;
    logic [11:0] mag_x;

    // hgfedcba, decimal point always off
    function automatic logic [7:0] hex_seg(input logic [3:0] nib);
        case (nib)
            4'h0: return 8'h3f;
            4'h1: return 8'h06;
            4'h2: return 8'h5b;
            4'h3: return 8'h4f;
            4'h4: return 8'h66;
            4'h5: return 8'h6d;
            4'h6: return 8'h7d;
            4'h7: return 8'h07;
            4'h8: return 8'h7f;
            4'h9: return 8'h6f;
            4'ha: return 8'h77;
            4'hb: return 8'h7c;
            4'hc: return 8'h39;
            4'hd: return 8'h5e;
            4'he: return 8'h79;
            default: return 8'h71;
        endcase
    endfunction

    always_comb
    begin
        peak_x = {1'b0, level.peak};
        mag_x  = {1'b0, level.mag};

        frame_next.segs[0] = hex_seg(peak_x[11:8]); // Peak, MSB first
        frame_next.segs[1] = hex_seg(peak_x[7:4]);
        frame_next.segs[2] = hex_seg(peak_x[3:0]);
        frame_next.segs[3] = 8'h00;                 // Blank gap
        frame_next.segs[4] = 8'h00;
        frame_next.segs[5] = hex_seg(mag_x[11:8]);  // Magnitude
        frame_next.segs[6] = hex_seg(mag_x[7:4]);
        frame_next.segs[7] = hex_seg(mag_x[3:0]);
        frame_next.leds    = level.bar;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            frame <= '0;
        else if (level.valid)
            frame <= frame_next;
    end

endmodule

// File: tm1638/tm1638_controller.sv
// TM1638 LED-and-key driver; refreshes digits and LEDs without pause and reads the 8 keys back
`timescale 1ns/1ps

module tm1638_controller
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  board_pkg::seg_frame_t frame,
    input  logic                  dio_in,
    output logic                  tm_clk,
    output logic                  stb,
    output logic                  dio_out,
    output logic                  dio_oe,
    output logic [7:0]            keys
);

    import board_pkg::*;

    typedef logic [$clog2(tm_clk_half)-1:0] div_t;

    tm_state_e  state;
    tm_state_e  next_trans; // Transaction after the strobe gap
    div_t       div_cnt;
    logic       tick;
    logic       phase;      // 0 drives clock low, 1 drives it high
    logic [2:0] bit_cnt;
    logic [3:0] byte_cnt;
    logic [7:0] tx_byte;
    logic [7:0] rx_byte;
    logic [7:0] keys_acc;
    logic [7:0] key_merge;
    logic       trans_start;
    seg_frame_t frame_q;

    // Even bytes carry segments, odd bytes one LED in bit 0
    function automatic logic [7:0] data_byte(input seg_frame_t f, input logic [3:0] n);
        if (n[0])
            return {7'b0, f.leds[n[3:1]]};
        return f.segs[n[3:1]];
    endfunction

    assign tick        = div_cnt == div_t'(tm_clk_half - 1);
    assign trans_start = tick && (state == idle || (state == strobe_gap && bit_cnt == 3'd7));

    // Bit 0 of read byte k is key k, bit 4 is key k+4
    always_comb
    begin
        key_merge                        = keys_acc;
        key_merge[byte_cnt[1:0]]         = rx_byte[1];
        key_merge[{1'b1, byte_cnt[1:0]}] = rx_byte[5];
    end

    // Whole refresh uses one frame
    always_ff @(posedge clk)
    begin
        if (trans_start && next_trans == write_addr)
            frame_q <= frame;
    end

    //----------------------------------------
    // Serial FSM

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state      <= idle;
            next_trans <= write_mode;
            div_cnt    <= '0;
            phase      <= 1'b0;
            bit_cnt    <= '0;
            byte_cnt   <= '0;
            tx_byte    <= '0;
            rx_byte    <= '0;
            keys_acc   <= '0;
            keys       <= '0;
            tm_clk     <= 1'b1;
            stb        <= 1'b1;
            dio_out    <= 1'b0;
            dio_oe     <= 1'b1;
        end
        else
        begin
            div_cnt <= tick ? '0 : div_cnt + 1'b1;

            if (trans_start)
            begin
                stb     <= 1'b0;
                state   <= next_trans;
                bit_cnt <= '0;
                phase   <= 1'b0;
                case (next_trans)
                    write_addr: tx_byte <= 8'hc0; // Address 0, auto increment
                    read_mode:  tx_byte <= 8'h42;
                    default:    tx_byte <= 8'h40;
                endcase
            end
            else if (tick && state == strobe_gap)
                bit_cnt <= bit_cnt + 1'b1;         // Gap of 4 clock periods
            else if (tick && !phase)
            begin
                tm_clk  <= 1'b0;
                dio_out <= tx_byte[bit_cnt];       // LSB first
                phase   <= 1'b1;
            end
            else if (tick)
            begin
                tm_clk  <= 1'b1;
                phase   <= 1'b0;
                rx_byte <= {dio_in, rx_byte[7:1]};
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == 3'd7)
                begin
                    case (state)
                        write_mode:
                        begin
                            stb        <= 1'b1;
                            state      <= strobe_gap;
                            next_trans <= write_addr;
                        end
                        write_addr:
                        begin
                            state    <= write_data;
                            byte_cnt <= '0;
                            tx_byte  <= data_byte(frame_q, 4'd0);
                        end
                        write_data:
                        begin
                            if (byte_cnt == 4'd15)
                            begin
                                stb        <= 1'b1;
                                state      <= strobe_gap;
                                next_trans <= read_mode;
                            end
                            else
                            begin
                                byte_cnt <= byte_cnt + 1'b1;
                                tx_byte  <= data_byte(frame_q, byte_cnt + 4'd1);
                            end
                        end
                        read_mode:
                        begin
                            state    <= read_keys;
                            byte_cnt <= '0;
                            tx_byte  <= '0;
                            dio_oe   <= 1'b0; // Release the line to the TM1638
                        end
                        read_keys:
                        begin
                            keys_acc <= key_merge;
                            if (byte_cnt == 4'd3)
                            begin
                                keys       <= key_merge;
                                stb        <= 1'b1;
                                dio_oe     <= 1'b1;
                                state      <= strobe_gap;
                                next_trans <= write_mode;
                            end
                            else
                                byte_cnt <= byte_cnt + 1'b1;
                        end
                        default: state <= idle;
                    endcase
                end
            end
        end
    end

endmodule

// File: logic/board_top.sv
// Board-level top; chains mic receiver, level meter, encoder and TM1638 driver, merges keys
`timescale 1ns/1ps

module board_top
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [board_pkg::w_key-1:0] BTN,
    input  logic [3:0]                  SW,
    input  logic                        mic_sdo,
    input  logic                        tm_dio_in,
    output logic [board_pkg::w_led-1:0] LED,
    output logic                        mic_cs,
    output logic                        mic_sck,
    output logic                        tm_clk,
    output logic                        tm_stb,
    output logic                        tm_dio_out,
    output logic                        tm_dio_oe
);

    import board_pkg::*;

    mic_sample_t         sample;
    level_t              level;
    seg_frame_t          frame;
    logic [w_tm_key-1:0] tm_keys;
    logic [w_key-1:0]    merged_keys;

    //----------------------------------------
    // Duplicate mode glue

    assign merged_keys = BTN | tm_keys[w_key-1:0]; // Either source presses the key
    assign LED         = level.bar[w_led-1:0];

    //----------------------------------------
    // Pipeline

    mic_spi_receiver i_mic
    (
        .clk    ( clk     ),
        .rst_n  ( rst_n   ),
        .sdo    ( mic_sdo ),
        .cs     ( mic_cs  ),
        .sck    ( mic_sck ),
        .sample ( sample  )
    );

    level_meter i_level
    (
        .clk        ( clk            ),
        .rst_n      ( rst_n          ),
        .sample     ( sample         ),
        .gain       ( SW[1:0]        ),
        .clear_peak ( merged_keys[0] ), // Key 0 restarts peak hold
        .level      ( level          )
    );

    seg_display_encoder i_encoder
    (
        .clk   ( clk   ),
        .rst_n ( rst_n ),
        .level ( level ),
        .frame ( frame )
    );

    tm1638_controller i_ledkey
    (
        .clk     ( clk        ),
        .rst_n   ( rst_n      ),
        .frame   ( frame      ),
        .dio_in  ( tm_dio_in  ),
        .tm_clk  ( tm_clk     ),
        .stb     ( tm_stb     ),
        .dio_out ( tm_dio_out ),
        .dio_oe  ( tm_dio_oe  ),
        .keys    ( tm_keys    )
    );

endmodule

// File: verification/board_top_tb.sv
// Board-level testbench; models the mic ADC and the TM1638, replays the stimulus file and checks
`timescale 1ns/1ps

module board_top_tb;

    import board_pkg::*;

    localparam time clk_period = 40ns;

    logic               clk;
    logic               rst_n;
    logic [w_key-1:0]   btn;
    logic [3:0]         sw;
    logic               mic_sdo;
    logic               tm_dio_in;
    logic [w_led-1:0]   led;
    logic               mic_cs;
    logic               mic_sck;
    logic               tm_clk;
    logic               tm_stb;
    logic               tm_dio_out;
    logic               tm_dio_oe;

    // Stimulus table
    logic [11:0] smp_q[$];
    logic [3:0]  sw_q[$];
    logic [3:0]  btn_q[$];
    logic [7:0]  key_q[$];
    logic [7:0]  bar_q[$];
    logic [10:0] peak_q[$];

    logic [15:0] mic_word;
    logic [15:0] mic_shift;
    int          mic_idx;
    logic        cs_prev;
    logic        sck_prev;

    logic [7:0]  tm_key_byte;      // Keys the TM1638 model reports
    logic        tclk_prev;
    logic        stb_prev;
    int          tbit;
    logic [7:0]  cur_byte;
    logic [7:0]  cmd;
    seg_frame_t  wr_frame;
    seg_frame_t  shown_frame;      // Last fully written refresh
    int          addr_count;
    int          read_count;
    time         watchdog_limit;
    logic        loaded;

    board_top board_top_inst
    (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .BTN        ( btn        ),
        .SW         ( sw         ),
        .mic_sdo    ( mic_sdo    ),
        .tm_dio_in  ( tm_dio_in  ),
        .LED        ( led        ),
        .mic_cs     ( mic_cs     ),
        .mic_sck    ( mic_sck    ),
        .tm_clk     ( tm_clk     ),
        .tm_stb     ( tm_stb     ),
        .tm_dio_out ( tm_dio_out ),
        .tm_dio_oe  ( tm_dio_oe  )
    );

    initial
    begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    //----------------------------------------
    // Reference rules

    function automatic logic [7:0] seg7(input logic [3:0] nib);
        logic [7:0] table_codes [16];
        table_codes = '{8'h3f, 8'h06, 8'h5b, 8'h4f, 8'h66, 8'h6d, 8'h7d, 8'h07,
                        8'h7f, 8'h6f, 8'h77, 8'h7c, 8'h39, 8'h5e, 8'h79, 8'h71};
        return table_codes[nib];
    endfunction

    // Distance from 2048, shifted by gain, clipped at 2047
    function automatic logic [10:0] expected_mag(input logic [11:0] s, input logic [1:0] g);
        int d;
        d = (s >= 12'h800) ? int'(s) - 2048 : 2048 - int'(s);
        d = d << g;
        if (d > 2047)
            d = 2047;
        return 11'(d);
    endfunction

    function automatic seg_frame_t expected_frame(input logic [10:0] peak, input logic [10:0] mag,
                                                  input logic [7:0] bar);
        seg_frame_t f;
        f.segs[0] = seg7({1'b0, peak[10:8]});
        f.segs[1] = seg7(peak[7:4]);
        f.segs[2] = seg7(peak[3:0]);
        f.segs[3] = 8'h00;
        f.segs[4] = 8'h00;
        f.segs[5] = seg7({1'b0, mag[10:8]});
        f.segs[6] = seg7(mag[7:4]);
        f.segs[7] = seg7(mag[3:0]);
        f.leds    = bar;
        return f;
    endfunction

    // Read byte k: bit 0 is key k, bit 4 is key k+4
    function automatic logic key_bit(input logic [7:0] keys, input int k, input int n);
        if (n == 0)
            return keys[k];
        if (n == 4)
            return keys[k + 4];
        return 1'b0;
    endfunction

    //----------------------------------------
    // Checks

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            fail_now($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_leds(input logic [w_led-1:0] got, input logic [w_led-1:0] exp);
        if (got !== exp)
            fail_now($sformatf("MISMATCH LED got 0x%h expected 0x%h", got, exp));
    endtask

    task automatic check_frame(input seg_frame_t got, input seg_frame_t exp);
        if (got !== exp)
            fail_now($sformatf("MISMATCH tm_frame got 0x%h expected 0x%h", got, exp));
    endtask

    task automatic check_state();
        check_bit("mic_cs", mic_cs, 1'b1);
        check_bit("mic_sck", mic_sck, 1'b0);
        check_bit("tm_stb", tm_stb, 1'b1);
        check_bit("tm_clk", tm_clk, 1'b1);
        check_bit("tm_dio_oe", tm_dio_oe, 1'b1);
        check_bit("tm_dio_out", tm_dio_out, 1'b0);
        check_leds(led, '0);
    endtask

    //----------------------------------------
    // Mic ADC model, new bit after each falling mic_sck

    always @(posedge clk)
    begin
        if (cs_prev && !mic_cs)
        begin
            mic_shift = mic_word;
            mic_sdo  <= mic_word[15];
            mic_idx   = 14;
        end
        else if (!mic_cs && sck_prev && !mic_sck && mic_idx >= 0)
        begin
            mic_sdo <= mic_shift[mic_idx];
            mic_idx  = mic_idx - 1;
        end
        cs_prev  = mic_cs;
        sck_prev = mic_sck;
    end

    //----------------------------------------
    // TM1638 model

    always @(posedge clk)
    begin
        if (!stb_prev && !tclk_prev && tm_clk)
        begin
            cur_byte[tbit % 8] = tm_dio_out;
            tbit = tbit + 1;
            if (tbit % 8 == 0)
            begin
                if (tbit == 8)
                    cmd = cur_byte;
                else if (cmd == 8'hc0 && tbit <= 136)
                begin
                    if ((tbit / 8) % 2 == 0)
                        wr_frame.segs[(tbit / 8 - 2) / 2] = cur_byte;
                    else
                        wr_frame.leds[(tbit / 8 - 2) / 2] = cur_byte[0];
                end
            end
        end
        if (!tm_stb && tclk_prev && !tm_clk && !tm_dio_oe && tbit >= 8)
            tm_dio_in <= key_bit(tm_key_byte, (tbit - 8) / 8, (tbit - 8) % 8);
        if (!stb_prev && tm_stb)
        begin
            if (cmd == 8'hc0 && tbit == 136)
            begin
                shown_frame = wr_frame;
                addr_count  = addr_count + 1;
            end
            else if (cmd == 8'h42 && tbit == 40)
                read_count = read_count + 1;
            tbit = 0;
        end
        tclk_prev = tm_clk;
        stb_prev  = tm_stb;
    end

    //----------------------------------------
    // Watchdog

    initial
    begin
        wait (loaded);
        #(watchdog_limit);
        fail_now("Timeout: the DUT stopped producing samples or TM1638 refreshes");
    end

    //----------------------------------------
    // Main sequence

    initial
    begin
        int          fd;
        int          n;
        int          start;
        int          key_start;
        string       line;
        logic [11:0] s;
        logic [3:0]  v_sw;
        logic [3:0]  v_btn;
        logic [7:0]  v_key;
        logic [7:0]  v_bar;
        logic [10:0] v_peak;
        logic [10:0] mag;

        rst_n       = 1'b0;
        btn         = '0;
        sw          = '0;
        mic_sdo     = 1'b0;
        tm_dio_in   = 1'b0;
        mic_word    = 16'h0800; // Mid-scale silence until the first line
        mic_shift   = '0;
        mic_idx     = -1;
        cs_prev     = 1'b1;
        sck_prev    = 1'b0;
        tm_key_byte = '0;
        tclk_prev   = 1'b1;
        stb_prev    = 1'b1;
        tbit        = 0;
        cur_byte    = '0;
        cmd         = '0;
        wr_frame    = '0;
        shown_frame = '0;
        addr_count  = 0;
        read_count  = 0;
        loaded      = 1'b0;

        fd = $fopen("verification/level_stimulus.txt", "r");
        if (fd == 0)
            fail_now("Could not open the stimulus file");
        while ($fgets(line, fd) > 0)
        begin
            if (line.len() < 2 || line[0] == "#")
                continue;
            n = $sscanf(line, "%h %h %h %h %h %h", s, v_sw, v_btn, v_key, v_bar, v_peak);
            if (n != 6)
                fail_now("Malformed line in the stimulus file");
            smp_q.push_back(s);
            sw_q.push_back(v_sw);
            btn_q.push_back(v_btn);
            key_q.push_back(v_key);
            bar_q.push_back(v_bar);
            peak_q.push_back(v_peak);
        end
        $fclose(fd);
        watchdog_limit = (smp_q.size() + 3) * mic_frame_cycles * clk_period;
        loaded = 1'b1;

        repeat (3) @(posedge clk);
        check_state();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        @(posedge clk);
        tm_key_byte <= key_q[0];
        key_start = read_count;

        for (int i = 0; i < smp_q.size(); i++)
        begin
            // New key byte must be fully read before the sample
            while (read_count < key_start + 2)
                @(posedge clk);
            while (!mic_cs)
                @(posedge clk);
            sw       <= sw_q[i];
            btn      <= btn_q[i];
            mic_word <= {4'h0, smp_q[i]};
            do @(posedge clk); while (mic_cs);
            do @(posedge clk); while (!mic_cs);
            if (i + 1 < smp_q.size())
            begin
                tm_key_byte <= key_q[i + 1]; // Read back during this sample period
                key_start = read_count;
            end
            start = addr_count;
            while (addr_count < start + 2)
                @(posedge clk);
            mag = expected_mag(smp_q[i], sw_q[i][1:0]);
            check_leds(led, bar_q[i][w_led-1:0]);
            check_frame(shown_frame, expected_frame(peak_q[i], mag, bar_q[i]));
        end

        $display("Regression passed");
        $finish;
    end

endmodule

// File: verification/level_stimulus.txt
# Columns, all hex: sample SW BTN tm_key expected_bar expected_peak
# Magnitude digits follow from sample and SW[1:0]
800 0 0 00 00 000
900 0 0 00 01 100
a80 0 0 00 07 280
400 0 0 00 0f 400
700 0 0 00 01 400
780 0 0 00 01 400
810 0 0 00 01 400
810 0 1 00 01 010
880 1 0 00 01 100
900 2 0 00 0f 400
900 3 0 00 ff 7ff
000 0 0 00 ff 7ff
7c0 1 0 00 01 7ff
7c0 1 0 01 01 080
600 0 0 00 03 200
700 3 0 10 ff 7ff
820 4 0 10 01 7ff

// File: project.f
common/board_pkg.sv
mic_spi/mic_spi_receiver.sv
logic/level_meter.sv
logic/seg_display_encoder.sv
tm1638/tm1638_controller.sv
logic/board_top.sv
verification/board_top_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f --top-module board_top_tb -o board_top_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed"
    exit $status
fi

./obj_dir/board_top_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed"
    exit $status
fi
exit 0
